// ==== bench/dual_issue_checker.sv ====
module dual_issue_checker
	import dual_issue_pkg::*;
(
	input logic      clk,
	input logic      rst,
	input logic      issue_valid,
	input logic      wb0_valid,
	input reg_addr_t wb0_rd,
	input logic      wb1_valid,
	input reg_addr_t wb1_rd
);

timeunit 1ns;
timeprecision 100ps;

int assert_errors = 0;

// reset reaches the result registers one edge after rst is sampled
wb_idle_after_reset: assert property (@(posedge clk) $past(rst) |-> !wb0_valid && !wb1_valid)
	else begin
		$error("wb valid set while in reset or one cycle after");
		assert_errors++;
	end

wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
	(!wb0_valid || wb0_rd != '0) && (!wb1_valid || wb1_rd != '0))
	else begin
		$error("valid write-back to register 0");
		assert_errors++;
	end

wb_rd_distinct: assert property (@(posedge clk) disable iff (rst)
	wb0_valid && wb1_valid |-> wb0_rd != wb1_rd)
	else begin
		$error("both write-back lanes target the same register");
		assert_errors++;
	end

// capture edge, then result edge
wb_from_issue: assert property (@(posedge clk) disable iff (rst)
	wb0_valid || wb1_valid |-> $past(issue_valid, 2))
	else begin
		$error("write-back without an issued pair two edges earlier");
		assert_errors++;
	end

endmodule

bind dual_issue_core dual_issue_checker chk(
	.clk, .rst, .issue_valid, .wb0_valid, .wb0_rd, .wb1_valid, .wb1_rd
);

// ==== bench/dual_issue_tb.sv ====
`include "dual_issue_defs.svh"

module dual_issue_tb
	import dual_issue_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam int NUM_DIRECTED  = 16;
localparam int NUM_ROWS      = NUM_DIRECTED + 40;
localparam int RESET_TIMEOUT = 20;

typedef struct {
	logic      issue;
	word_t     instr0;
	word_t     instr1;
	logic      v0;
	reg_addr_t rd0;
	word_t     d0;
	logic      v1;
	reg_addr_t rd1;
	word_t     d1;
} row_t;

logic      clk;
logic      rst;
logic      issue_valid;
word_t     instr0;
word_t     instr1;
logic      wb0_valid;
reg_addr_t wb0_rd;
word_t     wb0_data;
logic      wb1_valid;
reg_addr_t wb1_rd;
word_t     wb1_data;

row_t   rows[NUM_ROWS];
int     row_count = 0;
integer seed = 32'h6bc5;

dual_issue_core uut(
	.clk, .rst, .issue_valid, .instr0, .instr1,
	.wb0_valid, .wb0_rd, .wb0_data, .wb1_valid, .wb1_rd, .wb1_data
);

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

initial begin
	repeat (5) @(posedge clk);
	#1 rst = 1'b0;
end

function automatic word_t encode_instr(input op_t op, input int rd, input int rs, input int rt,
		input logic [15:0] imm);
	return {op, 4'(rd), 4'(rs), 4'(rt), imm};
endfunction

// architectural result of one instruction
function automatic word_t ref_result(input word_t instr, input word_t a, input word_t b);
	logic [15:0] imm;
	imm = instr[15:0];
	case (instr[31:28])
		OP_ADD:  return a + b;
		OP_SUB:  return a - b;
		OP_AND:  return a & b;
		OP_OR:   return a | b;
		OP_XOR:  return a ^ b;
		OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		OP_SLL:  return a << b[4:0];
		OP_SRL:  return a >> b[4:0];
		OP_ADDI: return a + {{16{imm[15]}}, imm};
		OP_LUI:  return {imm, 16'h0000};
		default: return '0;
	endcase
endfunction

task automatic add_row(input logic issue, input word_t i0, input word_t i1);
	rows[row_count].issue  = issue;
	rows[row_count].instr0 = i0;
	rows[row_count].instr1 = i1;
	row_count++;
endtask

task automatic add_directed_rows();
	add_row(0, encode_instr(OP_ADD, 1, 0, 0, 0), encode_instr(OP_ADD, 2, 0, 0, 0));
	add_row(1, encode_instr(OP_LUI, 1, 0, 0, 16'h1234), encode_instr(OP_ADDI, 2, 0, 0, 16'hfffb));
	add_row(1, encode_instr(OP_ADDI, 1, 1, 0, 16'h5678), encode_instr(OP_LUI, 3, 0, 0, 16'h8000));
	add_row(1, encode_instr(OP_ADDI, 4, 0, 0, 16'd7), encode_instr(OP_ADDI, 5, 2, 0, 16'd3));
	add_row(1, encode_instr(OP_ADD, 6, 1, 2, 0), encode_instr(OP_SUB, 7, 4, 5, 0));
	add_row(1, encode_instr(OP_AND, 8, 1, 3, 0), encode_instr(OP_OR, 9, 6, 4, 0));
	add_row(1, encode_instr(OP_XOR, 10, 6, 7, 0), encode_instr(OP_SLT, 11, 2, 4, 0));
	add_row(1, encode_instr(OP_SLL, 12, 1, 4, 0), encode_instr(OP_SRL, 13, 3, 4, 0));
	add_row(1, encode_instr(OP_SLT, 14, 4, 2, 0), encode_instr(OP_SLT, 15, 3, 4, 0));
	// same rd in both lanes
	add_row(1, encode_instr(OP_ADDI, 5, 0, 0, 16'd100), encode_instr(OP_ADDI, 5, 0, 0, 16'd200));
	add_row(1, encode_instr(OP_ADD, 6, 5, 0, 0), encode_instr(OP_ADDI, 0, 4, 0, 16'd9));
	add_row(1, encode_instr(OP_ADD, 7, 0, 4, 0), encode_instr(OP_NOP, 0, 0, 0, 0));
	// not issued, r7 and r8 must keep their values
	add_row(0, encode_instr(OP_ADDI, 7, 0, 0, 16'h55), encode_instr(OP_ADDI, 8, 0, 0, 16'h66));
	add_row(1, encode_instr(OP_NOP, 0, 0, 0, 0), encode_instr(OP_OR, 8, 7, 0, 0));
	add_row(1, encode_instr(OP_ADDI, 9, 0, 0, 16'd1), encode_instr(OP_ADDI, 10, 0, 0, 16'd2));
	add_row(1, encode_instr(OP_ADD, 11, 9, 10, 0), encode_instr(OP_SUB, 12, 9, 6, 0));
endtask

task automatic add_random_rows();
	word_t w0;
	word_t w1;
	for (int n = NUM_DIRECTED; n < NUM_ROWS; ++n) begin
		w0 = $random(seed);
		w1 = $random(seed);
		w0[31:28] = 4'($unsigned($random(seed)) % 11);
		w1[31:28] = 4'($unsigned($random(seed)) % 11);
		// lane 1 never reads lane 0's destination
		if (w1[23:20] == w0[27:24])
			w1[23:20] = w0[27:24] + 4'd1;
		if (w1[19:16] == w0[27:24])
			w1[19:16] = w0[27:24] + 4'd1;
		add_row(($random(seed) & 3) != 0, w0, w1);
	end
endtask

task automatic build_expected();
	word_t     regs[`REG_NUM];
	word_t     r0;
	word_t     r1;
	logic      act0;
	logic      act1;
	reg_addr_t d0;
	reg_addr_t d1;
	for (int r = 0; r < `REG_NUM; ++r)
		regs[r] = '0;
	for (int i = 0; i < NUM_ROWS; ++i) begin
		act0 = rows[i].issue && rows[i].instr0[31:28] != OP_NOP && rows[i].instr0[31:28] <= OP_LUI;
		act1 = rows[i].issue && rows[i].instr1[31:28] != OP_NOP && rows[i].instr1[31:28] <= OP_LUI;
		d0 = rows[i].instr0[27:24];
		d1 = rows[i].instr1[27:24];
		r0 = ref_result(rows[i].instr0, regs[rows[i].instr0[23:20]], regs[rows[i].instr0[19:16]]);
		r1 = ref_result(rows[i].instr1, regs[rows[i].instr1[23:20]], regs[rows[i].instr1[19:16]]);
		rows[i].v0  = act0 && d0 != '0 && !(act1 && d1 == d0);
		rows[i].v1  = act1 && d1 != '0;
		rows[i].rd0 = d0;
		rows[i].rd1 = d1;
		rows[i].d0  = r0;
		rows[i].d1  = r1;
		if (rows[i].v0)
			regs[d0] = r0;
		if (rows[i].v1)
			regs[d1] = r1;
	end
endtask

task automatic abort_run(input string why);
	$display("%s", why);
	$display("TEST FAIL");
	$fatal(1, "simulation stopped");
endtask

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
	if (actual !== expected) begin
		$display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
		$display("TEST FAIL");
		$fatal(1, "value mismatch");
	end
endtask

task automatic check_row(input int idx);
	check_value(32'(wb0_valid), 32'(rows[idx].v0), $sformatf("row %0d wb0_valid", idx));
	check_value(32'(wb1_valid), 32'(rows[idx].v1), $sformatf("row %0d wb1_valid", idx));
	if (rows[idx].v0) begin
		check_value(32'(wb0_rd), 32'(rows[idx].rd0), $sformatf("row %0d wb0_rd", idx));
		check_value(wb0_data, rows[idx].d0, $sformatf("row %0d wb0_data", idx));
	end
	if (rows[idx].v1) begin
		check_value(32'(wb1_rd), 32'(rows[idx].rd1), $sformatf("row %0d wb1_rd", idx));
		check_value(wb1_data, rows[idx].d1, $sformatf("row %0d wb1_data", idx));
	end
endtask

initial begin
	int waited;
	rst = 1'b1;
	issue_valid = 1'b0;
	instr0 = '0;
	instr1 = '0;
	add_directed_rows();
	add_random_rows();
	build_expected();
	waited = 0;
	while (rst) begin
		@(posedge clk);
		waited++;
		if (waited > RESET_TIMEOUT)
			abort_run("reset was never released");
	end
	// a row driven now shows on wb two iterations later
	for (int i = 0; i < NUM_ROWS + 2; ++i) begin
		@(posedge clk);
		#1;
		if (uut.chk.assert_errors != 0)
			abort_run("an assertion in the checker failed");
		if (i >= 2)
			check_row(i - 2);
		if (i < NUM_ROWS) begin
			issue_valid = rows[i].issue;
			instr0 = rows[i].instr0;
			instr1 = rows[i].instr1;
		end else begin
			issue_valid = 1'b0;
		end
	end
	$display("TEST PASS");
	$finish;
end

endmodule

// ==== common/dual_issue_defs.svh ====
`ifndef DUAL_ISSUE_DEFS_SVH
`define DUAL_ISSUE_DEFS_SVH

// lanes issued per cycle
`define ISSUE_NUM 2

// architectural registers
`define REG_NUM 16

`define DATA_WIDTH 32

`endif

// ==== common/dual_issue_pkg.sv ====
`include "dual_issue_defs.svh"

package dual_issue_pkg;

typedef logic [$clog2(`REG_NUM)-1:0] reg_addr_t;
typedef logic [`DATA_WIDTH-1:0]      word_t;

// instruction bits 31..28
typedef enum logic [3:0] {
	OP_NOP  = 4'd0,
	OP_ADD  = 4'd1,
	OP_SUB  = 4'd2,
	OP_AND  = 4'd3,
	OP_OR   = 4'd4,
	OP_XOR  = 4'd5,
	OP_SLT  = 4'd6,
	OP_SLL  = 4'd7,
	OP_SRL  = 4'd8,
	OP_ADDI = 4'd9,
	OP_LUI  = 4'd10
} op_t;

// one decoded lane, operands already resolved
typedef struct packed {
	logic      valid;
	op_t       op;
	reg_addr_t rd;
	word_t     src_a;
	word_t     src_b;
} lane_op_t;

typedef struct packed {
	logic      valid;
	reg_addr_t rd;
	word_t     wdata;
} lane_result_t;

endpackage

// ==== common/issue_lane_if.sv ====
interface issue_lane_if
	import dual_issue_pkg::*;
();

logic      valid;
op_t       op;
reg_addr_t rd;
word_t     src_a;
word_t     src_b;

modport issue (
	output valid, op, rd, src_a, src_b
);

modport exec (
	input valid, op, rd, src_a, src_b
);

endinterface

// ==== design/dual_issue_core.sv ====
`include "dual_issue_defs.svh"

module dual_issue_core
	import dual_issue_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      issue_valid,
	input  word_t     instr0,
	input  word_t     instr1,
	output logic      wb0_valid,
	output reg_addr_t wb0_rd,
	output word_t     wb0_data,
	output logic      wb1_valid,
	output reg_addr_t wb1_rd,
	output word_t     wb1_data
);

// register file ports
logic      [`ISSUE_NUM-1:0]   reg_we;
reg_addr_t [`ISSUE_NUM-1:0]   reg_waddr;
word_t     [`ISSUE_NUM-1:0]   reg_wdata;
reg_addr_t [2*`ISSUE_NUM-1:0] reg_raddr;
word_t     [2*`ISSUE_NUM-1:0] reg_rdata;

// lane results, unregistered and registered
lane_result_t [`ISSUE_NUM-1:0] exec_next;
lane_result_t [`ISSUE_NUM-1:0] exec_result;
lane_result_t [`ISSUE_NUM-1:0] commit;

issue_lane_if lane_bus[`ISSUE_NUM] ();

decode_and_issue decode_issue_inst(
	.clk,
	.rst,
	.issue_valid,
	.instr0,
	.instr1,
	.reg_raddr ( reg_raddr ),
	.reg_rdata ( reg_rdata ),
	.exec_fwd  ( exec_next ),
	.wb_fwd    ( commit    ),
	.lanes     ( lane_bus  )
);

for(genvar i = 0; i < `ISSUE_NUM; ++i) begin : gen_exec
	instr_exec exec_inst(
		.clk,
		.rst,
		.lane        ( lane_bus[i]    ),
		.next_result ( exec_next[i]   ),
		.result      ( exec_result[i] )
	);
end

write_back write_back_inst(
	.lane_res ( exec_result ),
	.commit   ( commit      ),
	.we       ( reg_we      ),
	.waddr    ( reg_waddr   ),
	.wdata    ( reg_wdata   )
);

regfile regfile_inst(
	.clk,
	.rst,
	.we    ( reg_we    ),
	.waddr ( reg_waddr ),
	.wdata ( reg_wdata ),
	.raddr ( reg_raddr ),
	.rdata ( reg_rdata )
);

assign wb0_valid = commit[0].valid;
assign wb0_rd    = commit[0].rd;
assign wb0_data  = commit[0].wdata;
assign wb1_valid = commit[1].valid;
assign wb1_rd    = commit[1].rd;
assign wb1_data  = commit[1].wdata;

endmodule

// ==== design/instr_exec.sv ====
`include "dual_issue_defs.svh"

module instr_exec
	import dual_issue_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	issue_lane_if.exec        lane,
	output lane_result_t      next_result,
	output lane_result_t      result
);

word_t alu_out;
logic  less;

assign less = $signed(lane.src_a) < $signed(lane.src_b);

always_comb begin
	case(lane.op)
		OP_ADD, OP_ADDI: alu_out = lane.src_a + lane.src_b;
		OP_SUB:          alu_out = lane.src_a - lane.src_b;
		OP_AND:          alu_out = lane.src_a & lane.src_b;
		OP_OR:           alu_out = lane.src_a | lane.src_b;
		OP_XOR:          alu_out = lane.src_a ^ lane.src_b;
		OP_SLT:          alu_out = {{(`DATA_WIDTH-1){1'b0}}, less};
		OP_SLL:          alu_out = lane.src_a << lane.src_b[4:0];
		OP_SRL:          alu_out = lane.src_a >> lane.src_b[4:0];
		// src_b already holds imm << 16
		OP_LUI:          alu_out = lane.src_b;
		default:         alu_out = '0;
	endcase
end

assign next_result.valid = lane.valid;
assign next_result.rd    = lane.rd;
assign next_result.wdata = alu_out;

always_ff @(posedge clk) begin
	if(rst) begin
		result.valid <= 1'b0;
	end else begin
		result <= next_result;
	end
end

endmodule

// ==== design/regfile.sv ====
`include "dual_issue_defs.svh"

module regfile
	import dual_issue_pkg::*;
(
	input  logic                           clk,
	input  logic                           rst,
	input  logic      [`ISSUE_NUM-1:0]     we,
	input  reg_addr_t [`ISSUE_NUM-1:0]     waddr,
	input  word_t     [`ISSUE_NUM-1:0]     wdata,
	input  reg_addr_t [2*`ISSUE_NUM-1:0]   raddr,
	output word_t     [2*`ISSUE_NUM-1:0]   rdata
);

word_t regs[`REG_NUM];

always_ff @(posedge clk) begin
	if(rst) begin
		for(int r = 0; r < `REG_NUM; ++r)
			regs[r] <= '0;
	end else begin
		// higher port written last and wins
		for(int w = 0; w < `ISSUE_NUM; ++w) begin
			if(we[w] && waddr[w] != '0)
				regs[waddr[w]] <= wdata[w];
		end
	end
end

always_comb begin
	for(int r = 0; r < 2*`ISSUE_NUM; ++r) begin
		if(raddr[r] == '0)
			rdata[r] = '0;
		else
			rdata[r] = regs[raddr[r]];
	end
end

endmodule

// ==== design/write_back.sv ====
`include "dual_issue_defs.svh"

module write_back
	import dual_issue_pkg::*;
(
	input  lane_result_t [`ISSUE_NUM-1:0] lane_res,
	output lane_result_t [`ISSUE_NUM-1:0] commit,
	output logic         [`ISSUE_NUM-1:0] we,
	output reg_addr_t    [`ISSUE_NUM-1:0] waddr,
	output word_t        [`ISSUE_NUM-1:0] wdata
);

always_comb begin
	commit = lane_res;
	for(int i = 0; i < `ISSUE_NUM; ++i) begin
		if(lane_res[i].rd == '0)
			commit[i].valid = 1'b0;
	end
	// same rd in one pair, lane 1 is the later write
	if(lane_res[0].valid && lane_res[1].valid && lane_res[0].rd == lane_res[1].rd)
		commit[0].valid = 1'b0;
end

for(genvar i = 0; i < `ISSUE_NUM; ++i) begin : gen_port
	assign we[i]    = commit[i].valid;
	assign waddr[i] = commit[i].rd;
	assign wdata[i] = commit[i].wdata;
end

endmodule

// ==== dual_issue.f ====
+incdir+common
common/dual_issue_pkg.sv
common/issue_lane_if.sv
issue/decode_and_issue.sv
design/instr_exec.sv
design/write_back.sv
design/regfile.sv
design/dual_issue_core.sv
bench/dual_issue_checker.sv
bench/dual_issue_tb.sv

// ==== issue/decode_and_issue.sv ====
`include "dual_issue_defs.svh"

module decode_and_issue
	import dual_issue_pkg::*;
(
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              issue_valid,
	input  word_t                             instr0,
	input  word_t                             instr1,
	output reg_addr_t    [2*`ISSUE_NUM-1:0]   reg_raddr,
	input  word_t        [2*`ISSUE_NUM-1:0]   reg_rdata,
	input  lane_result_t [`ISSUE_NUM-1:0]     exec_fwd,
	input  lane_result_t [`ISSUE_NUM-1:0]     wb_fwd,
	issue_lane_if.issue                       lanes[`ISSUE_NUM]
);

word_t    [`ISSUE_NUM-1:0] instr;
lane_op_t [`ISSUE_NUM-1:0] next_op;
lane_op_t [`ISSUE_NUM-1:0] op_q;

assign instr = {instr1, instr0};

function automatic op_t decode_op(input logic [3:0] code);
	// unused codes past LUI run as NOP
	if(code > 4'(OP_LUI))
		return OP_NOP;
	return op_t'(code);
endfunction

// youngest source last so it overrides older ones
function automatic word_t select_operand(input reg_addr_t addr, input word_t rf_data);
	word_t val;
	val = rf_data;
	if(addr != '0) begin
		for(int s = 0; s < `ISSUE_NUM; ++s) begin
			if(wb_fwd[s].valid && wb_fwd[s].rd == addr)
				val = wb_fwd[s].wdata;
		end
		for(int s = 0; s < `ISSUE_NUM; ++s) begin
			if(exec_fwd[s].valid && exec_fwd[s].rd == addr)
				val = exec_fwd[s].wdata;
		end
	end
	return val;
endfunction

always_comb begin
	for(int i = 0; i < `ISSUE_NUM; ++i) begin
		reg_raddr[2*i]     = instr[i][23:20];
		reg_raddr[2*i + 1] = instr[i][19:16];

		next_op[i].op    = decode_op(instr[i][31:28]);
		next_op[i].valid = issue_valid && next_op[i].op != OP_NOP;
		next_op[i].rd    = instr[i][27:24];
		next_op[i].src_a = select_operand(instr[i][23:20], reg_rdata[2*i]);

		// immediate replaces rt for I-type ops
		case(next_op[i].op)
			OP_ADDI: next_op[i].src_b = {{(`DATA_WIDTH-16){instr[i][15]}}, instr[i][15:0]};
			OP_LUI:  next_op[i].src_b = {instr[i][15:0], {(`DATA_WIDTH-16){1'b0}}};
			default: next_op[i].src_b = select_operand(instr[i][19:16], reg_rdata[2*i + 1]);
		endcase
	end
end

always_ff @(posedge clk) begin
	if(rst) begin
		for(int i = 0; i < `ISSUE_NUM; ++i)
			op_q[i].valid <= 1'b0;
	end else begin
		op_q <= next_op;
	end
end

for(genvar i = 0; i < `ISSUE_NUM; ++i) begin : gen_lane_out
	assign lanes[i].valid = op_q[i].valid;
	assign lanes[i].op    = op_q[i].op;
	assign lanes[i].rd    = op_q[i].rd;
	assign lanes[i].src_a = op_q[i].src_a;
	assign lanes[i].src_b = op_q[i].src_b;
end

endmodule
